//--- hdl/core_consts.svh
`ifndef CORE_CONSTS_SVH
`define CORE_CONSTS_SVH

// ------------------------------
// Data path widths
// ------------------------------
`define XLEN            32
`define REG_COUNT       32
`define REG_INDEX_W     5

// ------------------------------
// Reset state
// ------------------------------
// First fetch address once reset is released
`define RESET_ADDRESS   32'h0000_0000

// addi x0, x0, 0
`define NOP_INSTRUCTION 32'h0000_0013

`endif

//--- hdl/rv_isa_pkg.sv
`default_nettype none

package rv_isa_pkg;

    // Base opcodes kept by this core
    typedef enum logic [6:0]
    {
        OP     = 7'b0110011,
        OP_IMM = 7'b0010011,
        LUI    = 7'b0110111,
        AUIPC  = 7'b0010111,
        STORE  = 7'b0100011
    } opcode_t;

    // ALU function codes, shared by OP and OP_IMM
    typedef enum logic [2:0]
    {
        ADD_SUB = 3'b000,
        SLL     = 3'b001,
        SLT     = 3'b010,
        SLTU    = 3'b011,
        XOR     = 3'b100,
        SRL_SRA = 3'b101,
        OR      = 3'b110,
        AND     = 3'b111
    } funct3_t;

    // Selects SUB and SRA/SRAI
    localparam logic [6:0] FUNCT7_ALT = 7'b0100000;
    localparam logic [2:0] FUNCT3_SW  = 3'b010;

    // ------------------------------
    // Instruction formats
    // ------------------------------
    typedef struct packed
    {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_t    funct3;
        logic [4:0] rd;
        opcode_t    opcode;
    } r_type_t;

    typedef struct packed
    {
        logic [11:0] imm;
        logic [4:0]  rs1;
        funct3_t     funct3;
        logic [4:0]  rd;
        opcode_t     opcode;
    } i_type_t;

    typedef struct packed
    {
        logic [6:0] imm_hi;
        logic [4:0] rs2;
        logic [4:0] rs1;
        funct3_t    funct3;
        logic [4:0] imm_lo;
        opcode_t    opcode;
    } s_type_t;

    typedef struct packed
    {
        logic [19:0] imm;
        logic [4:0]  rd;
        opcode_t     opcode;
    } u_type_t;

endpackage

`default_nettype wire

//--- hdl/core_pkg.sv
`default_nettype none

`include "core_consts.svh"

package core_pkg;

    typedef logic [`XLEN-1:0]        word_t;
    typedef logic [`REG_INDEX_W-1:0] reg_index_t;

    // Operations carried out by the execute stage
    typedef enum logic [3:0]
    {
        ADD,
        SUB,
        SLL,
        SLT,
        SLTU,
        XOR,
        SRL,
        SRA,
        OR,
        AND,
        PASS_B      // Immediate straight through for LUI
    } alu_op_t;

endpackage

`default_nettype wire

//--- hdl/fetch_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_consts.svh"

module fetch_unit
(
    input  logic           clk,
    input  logic           reset,
    output core_pkg::word_t pc
);

    // ------------------------------
    // Program counter
    // ------------------------------
    // No stalls or redirects, so the address steps every cycle
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pc <= `RESET_ADDRESS;
        end
        else
        begin
            pc <= pc + core_pkg::word_t'(4);
        end
    end

endmodule

`default_nettype wire

//--- hdl/decode_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_consts.svh"

module decode_unit
(
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::word_t      fetch_pc,
    input  logic [31:0]          instruction,
    output core_pkg::word_t      decode_pc,
    output core_pkg::reg_index_t read_index_1,
    output core_pkg::reg_index_t read_index_2,
    output core_pkg::reg_index_t write_index,
    output logic                 write_enable,
    output logic                 store_enable,
    output logic                 use_immediate,
    output core_pkg::alu_op_t    alu_op,
    output core_pkg::word_t      immediate,
    output logic                 pc_relative
);

    logic [31:0]         instruction_q;
    rv_isa_pkg::r_type_t r_fields;
    rv_isa_pkg::i_type_t i_fields;
    rv_isa_pkg::s_type_t s_fields;
    rv_isa_pkg::u_type_t u_fields;
    logic                alt_function;

    // Maps funct3 plus the funct7 alternate bit onto one ALU operation
    function automatic core_pkg::alu_op_t alu_select
    (
        input rv_isa_pkg::funct3_t funct3,
        input logic                alt,
        input logic                reg_form
    );
        core_pkg::alu_op_t op;
        case (funct3)
            rv_isa_pkg::ADD_SUB: op = (alt && reg_form) ? core_pkg::SUB : core_pkg::ADD;
            rv_isa_pkg::SLL:     op = core_pkg::SLL;
            rv_isa_pkg::SLT:     op = core_pkg::SLT;
            rv_isa_pkg::SLTU:    op = core_pkg::SLTU;
            rv_isa_pkg::XOR:     op = core_pkg::XOR;
            rv_isa_pkg::SRL_SRA: op = alt ? core_pkg::SRA : core_pkg::SRL;
            rv_isa_pkg::OR:      op = core_pkg::OR;
            rv_isa_pkg::AND:     op = core_pkg::AND;
            default:             op = core_pkg::ADD;
        endcase
        return op;
    endfunction

    // ------------------------------
    // Fetch to decode register
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            instruction_q <= `NOP_INSTRUCTION;
        end
        else
        begin
            instruction_q <= instruction;
        end
        decode_pc <= fetch_pc;
    end

    // Same word seen through each format
    assign r_fields = rv_isa_pkg::r_type_t'(instruction_q);
    assign i_fields = rv_isa_pkg::i_type_t'(instruction_q);
    assign s_fields = rv_isa_pkg::s_type_t'(instruction_q);
    assign u_fields = rv_isa_pkg::u_type_t'(instruction_q);

    assign read_index_1 = r_fields.rs1;
    assign read_index_2 = r_fields.rs2;
    assign write_index  = r_fields.rd;
    assign alt_function = (r_fields.funct7 == rv_isa_pkg::FUNCT7_ALT);

    // ------------------------------
    // Control and immediate
    // ------------------------------
    always_comb
    begin
        write_enable  = 1'b0;
        store_enable  = 1'b0;
        use_immediate = 1'b1;
        pc_relative   = 1'b0;
        alu_op        = core_pkg::ADD;
        immediate     = '0;
        case (r_fields.opcode)
            rv_isa_pkg::OP:
            begin
                write_enable  = 1'b1;
                use_immediate = 1'b0;
                alu_op        = alu_select(r_fields.funct3, alt_function, 1'b1);
            end
            rv_isa_pkg::OP_IMM:
            begin
                write_enable = 1'b1;
                immediate    = core_pkg::word_t'($signed(i_fields.imm));
                alu_op       = alu_select(i_fields.funct3, alt_function, 1'b0);
            end
            rv_isa_pkg::LUI:
            begin
                write_enable = 1'b1;
                immediate    = {u_fields.imm, 12'b0};
                alu_op       = core_pkg::PASS_B;
            end
            rv_isa_pkg::AUIPC:
            begin
                write_enable = 1'b1;
                immediate    = {u_fields.imm, 12'b0};
                pc_relative  = 1'b1;
            end
            rv_isa_pkg::STORE:
            begin
                // Only word stores are issued
                store_enable = (s_fields.funct3 == rv_isa_pkg::FUNCT3_SW);
                immediate    = core_pkg::word_t'($signed({s_fields.imm_hi, s_fields.imm_lo}));
            end
            default:
            begin
                write_enable = 1'b0;
            end
        endcase
    end

endmodule

`default_nettype wire

//--- hdl/register_file.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_consts.svh"

module register_file
(
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::reg_index_t read_index_1,
    input  core_pkg::reg_index_t read_index_2,
    input  core_pkg::reg_index_t write_index,
    input  logic                 write_enable,
    input  core_pkg::word_t      write_data,
    output core_pkg::word_t      read_data_1,
    output core_pkg::word_t      read_data_2
);

    core_pkg::word_t registers [`REG_COUNT];

    // x0 is cleared here and never written, so it always reads zero
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
            begin
                registers[i] <= '0;
            end
        end
        else if (write_enable && write_index != '0)
        begin
            registers[write_index] <= write_data;
        end
    end

    // Combinational read ports
    assign read_data_1 = registers[read_index_1];
    assign read_data_2 = registers[read_index_2];

endmodule

`default_nettype wire

//--- hdl/forward_unit.sv
`default_nettype none
`timescale 1ns/100ps

module forward_unit
(
    input  core_pkg::reg_index_t source_index,
    input  core_pkg::word_t      register_data,
    input  logic                 ex_write_enable,
    input  core_pkg::reg_index_t ex_write_index,
    input  core_pkg::word_t      ex_result,
    input  logic                 wb_write_enable,
    input  core_pkg::reg_index_t wb_write_index,
    input  core_pkg::word_t      wb_write_data,
    output core_pkg::word_t      operand
);

    logic ex_match;
    logic wb_match;

    // x0 never takes a bypass
    assign ex_match = ex_write_enable && (source_index != '0) &&
                      (ex_write_index == source_index);
    assign wb_match = wb_write_enable && (source_index != '0) &&
                      (wb_write_index == source_index);

    // Youngest producer wins
    always_comb
    begin
        if (ex_match)
            operand = ex_result;
        else if (wb_match)
            operand = wb_write_data;
        else
            operand = register_data;
    end

endmodule

`default_nettype wire

//--- hdl/execute_unit.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_consts.svh"

module execute_unit
(
    input  logic                 clk,
    input  logic                 reset,
    input  core_pkg::word_t      decode_pc,
    input  core_pkg::word_t      operand_1,
    input  core_pkg::word_t      operand_2,
    input  core_pkg::word_t      immediate,
    input  core_pkg::alu_op_t    alu_op,
    input  logic                 use_immediate,
    input  logic                 pc_relative,
    input  logic                 write_enable,
    input  logic                 store_enable,
    input  core_pkg::reg_index_t write_index,
    output logic                 ex_write_enable,
    output core_pkg::reg_index_t ex_write_index,
    output core_pkg::word_t      ex_result,
    output logic                 wb_write_enable,
    output core_pkg::reg_index_t wb_write_index,
    output core_pkg::word_t      wb_write_data,
    output logic                 store_valid,
    output core_pkg::word_t      store_address,
    output core_pkg::word_t      store_data
);

    localparam int SHAMT_W = $clog2(`XLEN);

    core_pkg::word_t   pc_q;
    core_pkg::word_t   operand_1_q;
    core_pkg::word_t   operand_2_q;
    core_pkg::word_t   immediate_q;
    core_pkg::alu_op_t alu_op_q;
    logic              use_immediate_q;
    logic              pc_relative_q;
    logic              store_enable_q;
    core_pkg::word_t   operand_a;
    core_pkg::word_t   operand_b;
    logic [SHAMT_W-1:0] shamt;

    // ------------------------------
    // Decode to execute register
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            ex_write_enable <= 1'b0;
            store_enable_q  <= 1'b0;
        end
        else
        begin
            ex_write_enable <= write_enable;
            store_enable_q  <= store_enable;
        end
        pc_q            <= decode_pc;
        operand_1_q     <= operand_1;
        operand_2_q     <= operand_2;
        immediate_q     <= immediate;
        alu_op_q        <= alu_op;
        use_immediate_q <= use_immediate;
        pc_relative_q   <= pc_relative;
        ex_write_index  <= write_index;
    end

    // AUIPC takes pc as operand A
    assign operand_a = pc_relative_q ? pc_q : operand_1_q;
    assign operand_b = use_immediate_q ? immediate_q : operand_2_q;
    assign shamt     = operand_b[SHAMT_W-1:0];

    // ------------------------------
    // ALU
    // ------------------------------
    always_comb
    begin
        case (alu_op_q)
            core_pkg::ADD:    ex_result = operand_a + operand_b;
            core_pkg::SUB:    ex_result = operand_a - operand_b;
            core_pkg::SLL:    ex_result = operand_a << shamt;
            core_pkg::SLT:    ex_result = core_pkg::word_t'($signed(operand_a) < $signed(operand_b));
            core_pkg::SLTU:   ex_result = core_pkg::word_t'(operand_a < operand_b);
            core_pkg::XOR:    ex_result = operand_a ^ operand_b;
            core_pkg::SRL:    ex_result = operand_a >> shamt;
            core_pkg::SRA:    ex_result = core_pkg::word_t'($signed(operand_a) >>> shamt);
            core_pkg::OR:     ex_result = operand_a | operand_b;
            core_pkg::AND:    ex_result = operand_a & operand_b;
            core_pkg::PASS_B: ex_result = operand_b;
            default:          ex_result = operand_a + operand_b;
        endcase
    end

    // ------------------------------
    // Execute to write-back register
    // ------------------------------
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_write_enable <= 1'b0;
            store_valid     <= 1'b0;
        end
        else
        begin
            wb_write_enable <= ex_write_enable;
            store_valid     <= store_enable_q;
        end
        wb_write_index <= ex_write_index;
        wb_write_data  <= ex_result;
        // Store address is rs1 plus the S immediate and store data is the forwarded rs2
        store_address  <= ex_result;
        store_data     <= operand_2_q;
    end

endmodule

`default_nettype wire

//--- hdl/core_top.sv
`default_nettype none
`timescale 1ns/100ps

module core_top
(
    input  logic            clk,
    input  logic            reset,
    input  logic [31:0]     imem_data,
    output core_pkg::word_t imem_address,
    output logic            store_valid,
    output core_pkg::word_t store_address,
    output core_pkg::word_t store_data
);

    // ------------------------------
    // Decode stage wires
    // ------------------------------
    core_pkg::word_t      decode_pc;
    core_pkg::reg_index_t read_index [2];
    core_pkg::reg_index_t write_index;
    logic                 write_enable;
    logic                 store_enable;
    logic                 use_immediate;
    logic                 pc_relative;
    core_pkg::alu_op_t    alu_op;
    core_pkg::word_t      immediate;
    core_pkg::word_t      read_data [2];
    core_pkg::word_t      operand [2];

    // ------------------------------
    // Bypass and write-back wires
    // ------------------------------
    logic                 ex_write_enable;
    core_pkg::reg_index_t ex_write_index;
    core_pkg::word_t      ex_result;
    logic                 wb_write_enable;
    core_pkg::reg_index_t wb_write_index;
    core_pkg::word_t      wb_write_data;

    fetch_unit fetch
    (
        .clk   (clk),
        .reset (reset),
        .pc    (imem_address)
    );

    decode_unit decode
    (
        .clk           (clk),
        .reset         (reset),
        .fetch_pc      (imem_address),
        .instruction   (imem_data),
        .decode_pc     (decode_pc),
        .read_index_1  (read_index[0]),
        .read_index_2  (read_index[1]),
        .write_index   (write_index),
        .write_enable  (write_enable),
        .store_enable  (store_enable),
        .use_immediate (use_immediate),
        .alu_op        (alu_op),
        .immediate     (immediate),
        .pc_relative   (pc_relative)
    );

    register_file registers
    (
        .clk          (clk),
        .reset        (reset),
        .read_index_1 (read_index[0]),
        .read_index_2 (read_index[1]),
        .write_index  (wb_write_index),
        .write_enable (wb_write_enable),
        .write_data   (wb_write_data),
        .read_data_1  (read_data[0]),
        .read_data_2  (read_data[1])
    );

    // One bypass selector per source operand
    for (genvar k = 0; k < 2; k++)
    begin : g_forward
        forward_unit forward
        (
            .source_index    (read_index[k]),
            .register_data   (read_data[k]),
            .ex_write_enable (ex_write_enable),
            .ex_write_index  (ex_write_index),
            .ex_result       (ex_result),
            .wb_write_enable (wb_write_enable),
            .wb_write_index  (wb_write_index),
            .wb_write_data   (wb_write_data),
            .operand         (operand[k])
        );
    end

    execute_unit execute
    (
        .clk             (clk),
        .reset           (reset),
        .decode_pc       (decode_pc),
        .operand_1       (operand[0]),
        .operand_2       (operand[1]),
        .immediate       (immediate),
        .alu_op          (alu_op),
        .use_immediate   (use_immediate),
        .pc_relative     (pc_relative),
        .write_enable    (write_enable),
        .store_enable    (store_enable),
        .write_index     (write_index),
        .ex_write_enable (ex_write_enable),
        .ex_write_index  (ex_write_index),
        .ex_result       (ex_result),
        .wb_write_enable (wb_write_enable),
        .wb_write_index  (wb_write_index),
        .wb_write_data   (wb_write_data),
        .store_valid     (store_valid),
        .store_address   (store_address),
        .store_data      (store_data)
    );

endmodule

`default_nettype wire

//--- tests/core_assert.sv
`default_nettype none
`timescale 1ns/100ps

module core_assert
(
    input logic            clk,
    input logic            reset,
    input core_pkg::word_t imem_address,
    input logic            store_valid
);

    // ------------------------------
    // Store port
    // ------------------------------
    store_valid_known: assert property (@(posedge clk) disable iff (reset)
        !$isunknown(store_valid))
        else $error("store_valid is unknown outside reset");

    store_idle_after_reset: assert property (@(posedge clk)
        $fell(reset) |-> !store_valid)
        else $error("store_valid high in the first cycle after reset");

    // Fetch never stalls
    address_step: assert property (@(posedge clk) disable iff (reset)
        !$past(reset) |-> imem_address == $past(imem_address) + 32'd4)
        else $error("imem_address did not advance by 4");

endmodule

bind core_top core_assert assert_i
(
    .clk          (clk),
    .reset        (reset),
    .imem_address (imem_address),
    .store_valid  (store_valid)
);

`default_nettype wire

//--- tests/core_tb.sv
`default_nettype none
`timescale 1ns/100ps

`include "core_consts.svh"

module core_tb;

    localparam int PROGRAM_WORDS = 64;
    localparam int RANDOM_COUNT  = 40;
    localparam int STORE_COUNT   = 7;
    localparam int STORE_TIMEOUT = 200;
    localparam int SETTLE_CYCLES = 20;

    logic            clk;
    logic            reset;
    logic [31:0]     imem_data;
    core_pkg::word_t imem_address;
    logic            store_valid;
    core_pkg::word_t store_address;
    core_pkg::word_t store_data;

    logic [31:0] program_words [PROGRAM_WORDS];
    logic [31:0] generated [PROGRAM_WORDS];
    logic [31:0] model_regs [`REG_COUNT];
    logic [31:0] expected_address [$];
    logic [31:0] expected_data [$];
    logic [31:0] expected_slot [$];
    int          mismatch_count = 0;
    int          other_error_count = 0;
    int          stores_seen = 0;
    logic        timed_out = 1'b0;

    core_top dut_i
    (
        .clk           (clk),
        .reset         (reset),
        .imem_data     (imem_data),
        .imem_address  (imem_address),
        .store_valid   (store_valid),
        .store_address (store_address),
        .store_data    (store_data)
    );

    // Combinational instruction memory that returns NOP outside the program
    assign imem_data = (imem_address[31:8] == '0) ? program_words[imem_address[7:2]]
                                                   : `NOP_INSTRUCTION;

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // ------------------------------
    // Program generation
    // ------------------------------
    function automatic logic [31:0] xorshift(input logic [31:0] state);
        logic [31:0] s;
        s = state;
        s = s ^ (s << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Registers limited to x0..x7 so dependences are dense
    function automatic logic [31:0] encode_random(input logic [31:0] r1, input logic [31:0] r2);
        logic [4:0]  rd;
        logic [4:0]  rs1;
        logic [4:0]  rs2;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [11:0] imm;
        logic [31:0] word;
        rd  = {2'b00, r1[6:4]};
        rs1 = {2'b00, r1[9:7]};
        rs2 = {2'b00, r1[12:10]};
        f3  = r1[15:13];
        // Alternate funct7 only where it means SUB or SRA
        f7  = (r1[16] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
        imm = r1[28:17];
        if (f3 == 3'b001 || f3 == 3'b101)
            imm = {f7, r1[21:17]};
        if (r1[3:0] < 4'd6)
            word = {f7, rs2, rs1, f3, rd, rv_isa_pkg::OP};
        else if (r1[3:0] < 4'd12)
            word = {imm, rs1, f3, rd, rv_isa_pkg::OP_IMM};
        else if (r1[3:0] < 4'd14)
            word = {r2[19:0], rd, rv_isa_pkg::LUI};
        else
            word = {r2[19:0], rd, rv_isa_pkg::AUIPC};
        return word;
    endfunction

    // sw source, offset(x0)
    function automatic logic [31:0] encode_store
    (
        input logic [4:0]  source,
        input logic [11:0] offset
    );
        return {offset[11:5], source, 5'd0, rv_isa_pkg::FUNCT3_SW, offset[4:0],
                rv_isa_pkg::STORE};
    endfunction

    // ------------------------------
    // Reference model
    // ------------------------------
    function automatic logic [31:0] reference_alu
    (
        input logic [2:0]  f3,
        input logic        alt,
        input logic [31:0] a,
        input logic [31:0] b
    );
        logic signed [31:0] sa;
        logic [31:0]        result;
        sa = a;
        case (f3)
            3'b000:  result = alt ? a - b : a + b;
            3'b001:  result = a << b[4:0];
            3'b010:  result = {31'b0, $signed(a) < $signed(b)};
            3'b011:  result = {31'b0, a < b};
            3'b100:  result = a ^ b;
            3'b101:
            begin
                if (alt)
                    result = sa >>> b[4:0];
                else
                    result = a >> b[4:0];
            end
            3'b110:  result = a | b;
            default: result = a & b;
        endcase
        return result;
    endfunction

    // Runs one instruction on model_regs and returns 1 with the store it issues
    function automatic logic reference_step
    (
        input  logic [31:0] instr,
        input  logic [31:0] pc,
        output logic [31:0] address,
        output logic [31:0] data
    );
        logic [4:0]  rd;
        logic [2:0]  f3;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm_i;
        logic [31:0] imm_s;
        logic [31:0] imm_u;
        logic [31:0] result;
        logic        writes;
        rd      = instr[11:7];
        f3      = instr[14:12];
        a       = model_regs[instr[19:15]];
        b       = model_regs[instr[24:20]];
        imm_i   = {{20{instr[31]}}, instr[31:20]};
        imm_s   = {{20{instr[31]}}, instr[31:25], instr[11:7]};
        imm_u   = {instr[31:12], 12'b0};
        address = '0;
        data    = '0;
        result  = '0;
        writes  = 1'b1;
        case (instr[6:0])
            rv_isa_pkg::OP:     result = reference_alu(f3, instr[31:25] == rv_isa_pkg::FUNCT7_ALT,
                                                       a, b);
            rv_isa_pkg::OP_IMM: result = reference_alu(f3, f3 == 3'b101 && instr[30], a, imm_i);
            rv_isa_pkg::LUI:    result = imm_u;
            rv_isa_pkg::AUIPC:  result = pc + imm_u;
            default:            writes = 1'b0;
        endcase
        if (writes && rd != 5'd0)
            model_regs[rd] = result;
        if (instr[6:0] == rv_isa_pkg::STORE && f3 == rv_isa_pkg::FUNCT3_SW)
        begin
            address = a + imm_s;
            data    = b;
            return 1'b1;
        end
        return 1'b0;
    endfunction

    // ------------------------------
    // Checking
    // ------------------------------
    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected)
        begin
            $display("MISMATCH time=%0t signal=%s expected=0x%08h actual=0x%08h",
                     $time, name, expected, actual);
            mismatch_count++;
        end
    endtask

    // Each store beat against the next expected store, in program order
    always @(negedge clk)
    begin
        if (!reset && store_valid)
        begin
            if (expected_address.size() == 0)
            begin
                $display("ERROR at %0t: store to 0x%08h beyond the expected sequence",
                         $time, store_address);
                other_error_count++;
            end
            else
            begin
                check_value("store_address", expected_address.pop_front(), store_address);
                check_value("store_data", expected_data.pop_front(), store_data);
                // Instruction at slot n stores in cycle n+3
                check_value("store_cycle", expected_slot.pop_front() + 32'd3, imem_address >> 2);
            end
            stores_seen++;
        end
    end

    initial
    begin
        logic [31:0] rng_state;
        logic [31:0] r1;
        logic [31:0] r2;
        logic [31:0] address;
        logic [31:0] data;
        int          waited;
        reset <= 1'b1;
        rng_state = 32'd25425;
        for (int i = 0; i < `REG_COUNT; i++)
            model_regs[i] = '0;
        for (int i = 0; i < PROGRAM_WORDS; i++)
        begin
            program_words[i] <= `NOP_INSTRUCTION;
            generated[i] = `NOP_INSTRUCTION;
        end
        for (int i = 0; i < RANDOM_COUNT; i++)
        begin
            rng_state = xorshift(rng_state);
            r1 = rng_state;
            rng_state = xorshift(rng_state);
            r2 = rng_state;
            generated[i] = encode_random(r1, r2);
        end
        for (int k = 1; k <= STORE_COUNT; k++)
            generated[RANDOM_COUNT + k - 1] = encode_store(5'(k), 12'((k - 1) * 4));
        for (int i = 0; i < PROGRAM_WORDS; i++)
        begin
            if (reference_step(generated[i], 32'(i * 4), address, data))
            begin
                expected_address.push_back(address);
                expected_data.push_back(data);
                expected_slot.push_back(32'(i));
            end
        end

        @(posedge clk);
        for (int i = 0; i < PROGRAM_WORDS; i++)
            program_words[i] <= generated[i];
        @(posedge clk);
        reset <= 1'b0;

        waited = 0;
        while (expected_address.size() != 0 && waited < STORE_TIMEOUT)
        begin
            @(posedge clk);
            waited++;
        end
        if (expected_address.size() != 0)
        begin
            $display("Timeout: %0d expected stores never arrived", expected_address.size());
            timed_out = 1'b1;
        end
        else
        begin
            // Quiet period to catch surplus stores
            waited = 0;
            while (waited < SETTLE_CYCLES)
            begin
                @(posedge clk);
                waited++;
            end
            check_value("store_count", 32'(STORE_COUNT), 32'(stores_seen));
        end

        $display("Errors: mismatches=%0d other=%0d timeouts=%0d",
                 mismatch_count, other_error_count, timed_out ? 1 : 0);
        if (mismatch_count == 0 && other_error_count == 0 && !timed_out)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

endmodule

`default_nettype wire

//--- src.f
+incdir+hdl
hdl/rv_isa_pkg.sv
hdl/core_pkg.sv
hdl/fetch_unit.sv
hdl/decode_unit.sv
hdl/register_file.sv
hdl/forward_unit.sv
hdl/execute_unit.sv
hdl/core_top.sv
tests/core_assert.sv
tests/core_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module core_tb -f src.f -o core_sim
output=$(./obj_dir/core_sim)
printf '%s\n' "$output"
if printf '%s\n' "$output" | grep -qx 'TB PASSED'
then
    exit 0
fi
echo "Simulation did not pass"
exit 1
